// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define XLEN   32
`define REG_AW 5

// Processor stage codes, 3 bits wide
`define ST_FETCH  3'd0
`define ST_DECODE 3'd1
`define ST_EXEC   3'd2
`define ST_MEM    3'd3
`define ST_WB     3'd4

// FPU cycles from enable to ready
`define FADD_LAT 4
`define FMUL_LAT 3

`endif

// ==== exec_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_SLL  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_SLT  = 5'd8,
        OP_SLTU = 5'd9,
        OP_PASS = 5'd10,
        OP_FADD = 5'd16,
        OP_FSUB = 5'd17,
        OP_FMUL = 5'd18
    } exec_op_e;

    // IEEE single precision fields
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } float_t;

    // ALU reads the integer view, FPU the float view
    typedef union packed {
        logic [`XLEN-1:0] word;
        float_t           fp;
    } operand_u;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   reg1_data;
        logic [`XLEN-1:0]   reg2_data;
        exec_op_e           ctl;
        logic               branch_uc;
        logic               branch_c;
        logic               branch_relative;
        logic               mem_read;
        logic               mem_write;
        logic               alu_pc;     // Operand 1 is pc
        logic               alu_src;    // Operand 2 is imm
        logic               reg_write;
        logic               writef;     // Float register file target
        logic               use_fpu;
        logic [`REG_AW-1:0] write_reg;
    } exec_in_t;

    typedef struct packed {
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
        logic               writef;
        logic [`REG_AW-1:0] write_reg;
        logic [`XLEN-1:0]   branch_addr;
        logic [`XLEN-1:0]   mem_addr;
        logic [`XLEN-1:0]   mem_write_data;
        logic [`XLEN-1:0]   reg_write_data;
        logic               branch;
    } exec_out_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu
    import exec_pkg::*;
(
    input  exec_op_e         ctl,
    input  operand_u         a,
    input  operand_u         b,
    output logic [`XLEN-1:0] y,
    output logic             zero
);

    logic [4:0] shamt;

    assign shamt = b.word[4:0];   // Low five bits only

    always_comb begin
        unique case (ctl)
            OP_ADD:  y = a.word + b.word;
            OP_SUB:  y = a.word - b.word;
            OP_AND:  y = a.word & b.word;
            OP_OR:   y = a.word | b.word;
            OP_XOR:  y = a.word ^ b.word;
            OP_SLL:  y = a.word << shamt;
            OP_SRL:  y = a.word >> shamt;
            OP_SRA:  y = $unsigned($signed(a.word) >>> shamt);
            OP_SLT: begin
                y = ($signed(a.word) < $signed(b.word)) ? `XLEN'd1 : `XLEN'd0;
            end
            OP_SLTU: begin
                y = (a.word < b.word) ? `XLEN'd1 : `XLEN'd0;
            end
            OP_PASS: y = b.word;
            default: y = '0;            // FPU codes
        endcase
    end

    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== fpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fpu
    import exec_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  exec_op_e         ctl,
    input  operand_u         a,
    input  operand_u         b,
    output logic [`XLEN-1:0] y,
    output logic             ready
);

    float_t     fa, fb;
    exec_op_e   op_q;
    logic [2:0] cnt;
    logic       busy;

    // Add/subtract path
    logic        a_big;
    logic [23:0] ma, mb;
    logic [23:0] m_big, m_small, m_small_sh;
    logic [7:0]  e_big, e_diff;
    logic        s_big;
    logic [24:0] m_sum;
    logic [4:0]  lz;
    logic [23:0] m_norm;
    logic signed [9:0] e_add;
    float_t      add_res;

    // Multiply path
    logic [47:0] prod;
    logic signed [9:0] e_mul;
    float_t      mul_res;

    function automatic logic [4:0] lead_zeros(input logic [23:0] m);
        logic [4:0] n;
        logic       found;
        n = 5'd0;
        found = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            if (!found && m[i]) begin
                found = 1'b1;
                n = 5'(23 - i);
            end
        end
        return n;
    endfunction

    // Denormals flush to zero through the hidden bit
    assign ma = (fa.exponent != 8'd0) ? {1'b1, fa.mantissa} : 24'd0;
    assign mb = (fb.exponent != 8'd0) ? {1'b1, fb.mantissa} : 24'd0;

    assign a_big      = {fa.exponent, fa.mantissa} >= {fb.exponent, fb.mantissa};
    assign m_big      = a_big ? ma : mb;
    assign m_small    = a_big ? mb : ma;
    assign e_big      = a_big ? fa.exponent : fb.exponent;
    assign s_big      = a_big ? fa.sign : fb.sign;
    assign e_diff     = a_big ? (fa.exponent - fb.exponent) : (fb.exponent - fa.exponent);
    assign m_small_sh = (e_diff > 8'd24) ? 24'd0 : (m_small >> e_diff);
    assign m_sum      = (fa.sign == fb.sign) ? ({1'b0, m_big} + {1'b0, m_small_sh})
                                             : ({1'b0, m_big} - {1'b0, m_small_sh});
    assign lz         = lead_zeros(m_sum[23:0]);
    assign m_norm     = m_sum[23:0] << lz;

    always_comb begin
        add_res = '0;
        if (m_sum[24]) begin
            e_add = $signed({2'b00, e_big}) + 10'sd1;
            add_res = '{sign: s_big, exponent: e_add[7:0], mantissa: m_sum[23:1]};
        end else begin
            e_add = $signed({2'b00, e_big}) - $signed({5'd0, lz});
            if (m_sum != '0 && e_add > 10'sd0) begin
                add_res = '{sign: s_big, exponent: e_add[7:0], mantissa: m_norm[22:0]};
            end
        end
    end

    assign prod  = ma * mb;
    assign e_mul = $signed({2'b00, fa.exponent}) + $signed({2'b00, fb.exponent})
                 - 10'sd127 + $signed({9'd0, prod[47]});

    always_comb begin
        mul_res = '0;
        if (ma != '0 && mb != '0 && e_mul > 10'sd0) begin
            mul_res.sign     = fa.sign ^ fb.sign;
            mul_res.exponent = e_mul[7:0];
            mul_res.mantissa = prod[47] ? prod[46:24] : prod[45:23];   // Truncated
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
            busy  <= 1'b0;
            cnt   <= '0;
        end else if (en) begin
            ready <= 1'b0;
            busy  <= 1'b1;
            cnt   <= (ctl == OP_FMUL) ? 3'(`FMUL_LAT - 1) : 3'(`FADD_LAT - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                ready <= 1'b1;
                busy  <= 1'b0;
            end else begin
                cnt <= cnt - 3'd1;
            end
        end
    end

    // Operand capture and result register
    always_ff @(posedge clk) begin
        if (en) begin
            fa   <= a.fp;
            fb   <= b.fp;
            op_q <= ctl;
            if (ctl == OP_FSUB) begin
                fb.sign <= ~b.fp.sign;
            end
        end else if (busy && cnt == '0) begin
            y <= (op_q == OP_FMUL) ? mul_res : add_res;
        end
    end

endmodule

`default_nettype wire

// ==== exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic [2:0] state,
    input  exec_in_t  instr,
    output exec_out_t result,
    output logic      data_ready
);

    operand_u         src1, src2;
    logic [`XLEN-1:0] alu_y;
    logic             alu_zero;
    logic [`XLEN-1:0] fpu_y;
    logic             fpu_ready;
    logic             fpu_en;
    logic             in_exec;
    logic             waiting;

    assign in_exec   = (state == `ST_EXEC);
    assign src1.word = instr.alu_pc ? instr.pc : instr.reg1_data;
    assign src2.word = instr.alu_src ? instr.imm : instr.reg2_data;
    assign fpu_en    = in_exec && !waiting && instr.use_fpu;   // Once per execute visit

    alu i_alu (
        .ctl  (instr.ctl),
        .a    (src1),
        .b    (src2),
        .y    (alu_y),
        .zero (alu_zero)
    );

    fpu i_fpu (
        .clk   (clk),
        .rst   (rst),
        .en    (fpu_en),
        .ctl   (instr.ctl),
        .a     (src1),
        .b     (src2),
        .y     (fpu_y),
        .ready (fpu_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            result     <= '0;
            data_ready <= 1'b0;
            waiting    <= 1'b0;
        end else if (in_exec) begin
            result.mem_read       <= instr.mem_read;
            result.mem_write      <= instr.mem_write;
            result.reg_write      <= instr.reg_write;
            result.writef         <= instr.writef;
            result.write_reg      <= instr.write_reg;
            result.branch         <= instr.branch_uc || (instr.branch_c && !alu_zero);
            result.branch_addr    <= instr.branch_relative ?
                                     (instr.branch_uc ? instr.pc + alu_y
                                                      : instr.pc + instr.imm) : alu_y;
            result.mem_addr       <= alu_y;
            result.mem_write_data <= instr.reg2_data;
            result.reg_write_data <= instr.branch_uc ? instr.pc + `XLEN'd4 :
                                     instr.use_fpu   ? fpu_y : alu_y;
            // FPU ready before the enable edge belongs to the last op
            data_ready            <= instr.use_fpu ? (fpu_ready && waiting) : 1'b1;
            waiting               <= 1'b1;
        end else begin
            waiting <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== stage_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module stage_sequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    input  logic       data_ready,
    output logic [2:0] state
);

    logic [2:0] next_state;
    logic       exec_seen;   // Past the first execute cycle

    always_comb begin
        next_state = state;
        unique case (state)
            `ST_FETCH:  if (issue) next_state = `ST_DECODE;
            `ST_DECODE: next_state = `ST_EXEC;
            `ST_EXEC: begin
                // Ready level in the first cycle is stale
                if (exec_seen && data_ready) next_state = `ST_MEM;
            end
            `ST_MEM:    next_state = `ST_WB;
            `ST_WB:     next_state = `ST_FETCH;
            default:    next_state = `ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= `ST_FETCH;
            exec_seen <= 1'b0;
        end else begin
            state     <= next_state;
            exec_seen <= (state == `ST_EXEC) && (next_state == `ST_EXEC);
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    input  exec_in_t   instr,
    output logic [2:0] state,
    output exec_out_t  result,
    output logic       data_ready
);

    // Sequencer state feeds the stage, ready comes back
    stage_sequencer i_stage_sequencer (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .data_ready (data_ready),
        .state      (state)
    );

    exec_stage i_exec_stage (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .instr      (instr),
        .result     (result),
        .data_ready (data_ready)
    );

endmodule

`default_nettype wire

// ==== exec_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_sva (
    input logic       clk,
    input logic       rst,
    input logic       issue,
    input logic [2:0] state
);

    int fail_count = 0;   // Read by the testbench at the end

    property legal_order_p;
        @(posedge clk) disable iff (rst)
            (state != $past(state)) |-> (state <= `ST_WB) &&
                (state == (($past(state) == `ST_WB) ? `ST_FETCH : $past(state) + 3'd1));
    endproperty

    property issue_to_exec_p;
        @(posedge clk) disable iff (rst)
            (state == `ST_FETCH && issue) |-> ##2 (state == `ST_EXEC);
    endproperty

    property decode_one_cycle_p;
        @(posedge clk) disable iff (rst)
            (state == `ST_DECODE) |=> (state == `ST_EXEC);
    endproperty

    legal_order_a: assert property (legal_order_p) else begin
        fail_count++;
        $error("State left its stage out of order");
    end

    issue_to_exec_a: assert property (issue_to_exec_p) else begin
        fail_count++;
        $error("Issue in fetch did not reach execute two cycles later");
    end

    decode_one_cycle_a: assert property (decode_one_cycle_p) else begin
        fail_count++;
        $error("Decode did not last exactly one cycle");
    end

endmodule

`default_nettype wire

// ==== exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_tb
    import exec_pkg::*;
();

    localparam int N_INSTR     = 39;
    localparam int CYCLE_LIMIT = 40 * N_INSTR + 100;

    logic       clk;
    logic       rst;
    logic       issue;
    exec_in_t   instr;
    logic [2:0] state;
    exec_out_t  result;
    logic       data_ready;
    int         errors = 0;
    int         cycles = 0;

    exec_unit_top i_exec_unit_top (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .instr      (instr),
        .state      (state),
        .result     (result),
        .data_ready (data_ready)
    );

    bind stage_sequencer exec_sva i_exec_sva (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .state (state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, writeback never came", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] alu_model(exec_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return 32'($signed(a) >>> b[4:0]);
            OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
            OP_SLTU: return {31'd0, a < b};
            OP_PASS: return b;
            default: return 32'd0;
        endcase
    endfunction

    // Single to double by rebias, exact for normal values
    function automatic real to_real(logic [31:0] f);
        logic [10:0] e;
        e = 11'(f[30:23]) + 11'd896;
        if (f[30:23] == 8'd0) return 0.0;
        return $bitstoreal({f[31], e, f[22:0], 29'd0});
    endfunction

    function automatic logic [31:0] to_single(real r);
        logic [63:0] d;
        logic [10:0] e;
        d = $realtobits(r);
        e = d[62:52] - 11'd896;
        if (d[62:0] == 63'd0) return {d[63], 31'd0};
        return {d[63], e[7:0], d[51:29]};
    endfunction

    function automatic logic [31:0] fpu_model(exec_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_FADD: return to_single(to_real(a) + to_real(b));
            OP_FSUB: return to_single(to_real(a) - to_real(b));
            default: return to_single(to_real(a) * to_real(b));
        endcase
    endfunction

    function automatic exec_out_t expected_result(exec_in_t ins);
        exec_out_t   r;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] y;
        r = '0;
        op1 = ins.alu_pc ? ins.pc : ins.reg1_data;
        op2 = ins.alu_src ? ins.imm : ins.reg2_data;
        y = alu_model(ins.ctl, op1, op2);   // Zero for float codes
        r.mem_read = ins.mem_read;
        r.mem_write = ins.mem_write;
        r.reg_write = ins.reg_write;
        r.writef = ins.writef;
        r.write_reg = ins.write_reg;
        r.branch = ins.branch_uc || (ins.branch_c && y != 32'd0);
        if (ins.branch_relative) begin
            r.branch_addr = ins.branch_uc ? ins.pc + y : ins.pc + ins.imm;
        end else begin
            r.branch_addr = y;
        end
        r.mem_addr = y;
        r.mem_write_data = ins.reg2_data;
        if (ins.branch_uc) begin
            r.reg_write_data = ins.pc + 32'd4;
        end else if (ins.use_fpu) begin
            r.reg_write_data = fpu_model(ins.ctl, op1, op2);
        end else begin
            r.reg_write_data = y;
        end
        return r;
    endfunction

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic exec_in_t random_instr(exec_op_e op);
        exec_in_t ins;
        ins = '0;
        ins.pc = $urandom & 32'hffff_fffc;
        ins.imm = $urandom;
        ins.reg1_data = $urandom;
        ins.reg2_data = $urandom;
        ins.ctl = op;
        ins.reg_write = 1'b1;
        ins.write_reg = 5'($urandom);
        return ins;
    endfunction

    // Issue from fetch, then check everything once writeback shows
    task automatic run_instr(exec_in_t ins);
        exec_out_t exp;
        int        n;
        exp = expected_result(ins);
        @(posedge clk);
        #1;
        instr = ins;
        issue = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            issue = 1'b0;
            n++;
            if (state == `ST_MEM) compare_field("data_ready", 32'd1, 32'(data_ready));
        end while (state != `ST_WB);
        if (!ins.use_fpu) compare_field("latency", 32'd5, 32'(n));
        compare_field("mem_read", 32'(exp.mem_read), 32'(result.mem_read));
        compare_field("mem_write", 32'(exp.mem_write), 32'(result.mem_write));
        compare_field("reg_write", 32'(exp.reg_write), 32'(result.reg_write));
        compare_field("writef", 32'(exp.writef), 32'(result.writef));
        compare_field("write_reg", 32'(exp.write_reg), 32'(result.write_reg));
        compare_field("branch", 32'(exp.branch), 32'(result.branch));
        compare_field("branch_addr", exp.branch_addr, result.branch_addr);
        compare_field("mem_addr", exp.mem_addr, result.mem_addr);
        compare_field("mem_write_data", exp.mem_write_data, result.mem_write_data);
        compare_field("reg_write_data", exp.reg_write_data, result.reg_write_data);
    endtask

    task automatic run_float(exec_op_e op, logic [31:0] a, logic [31:0] b);
        exec_in_t ins;
        ins = random_instr(op);
        ins.reg1_data = a;
        ins.reg2_data = b;
        ins.use_fpu = 1'b1;
        ins.writef = 1'b1;
        run_instr(ins);
    endtask

    initial begin
        exec_in_t ins;
        void'($urandom(32'h3787));
        rst = 1'b1;
        issue = 1'b0;
        instr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_field("state", 32'(`ST_FETCH), 32'(state));
        compare_field("data_ready", 32'd0, 32'(data_ready));
        compare_field("result flags", 32'd0, 32'({result.mem_read, result.mem_write,
                      result.reg_write, result.writef, result.branch}));

        for (int k = 0; k <= 10; k++) begin
            for (int m = 0; m < 2; m++) begin
                ins = random_instr(exec_op_e'(5'(k)));
                ins.alu_pc = m[0];
                ins.alu_src = m[0];
                run_instr(ins);
            end
        end

        for (int m = 0; m < 4; m++) begin
            ins = random_instr(OP_SUB);
            ins.branch_c = 1'b1;
            ins.branch_relative = m[1];
            ins.reg_write = 1'b0;
            if (m[0]) ins.reg2_data = ins.reg1_data;   // Not taken
            run_instr(ins);
        end
        for (int m = 0; m < 2; m++) begin
            ins = random_instr(m[0] ? OP_PASS : OP_ADD);
            ins.branch_uc = 1'b1;
            ins.branch_relative = m[0];
            ins.alu_src = ~m[0];   // Relative target then differs from pc+imm
            run_instr(ins);
        end

        for (int m = 0; m < 2; m++) begin
            ins = random_instr(OP_ADD);
            ins.alu_src = 1'b1;
            ins.mem_read = ~m[0];
            ins.mem_write = m[0];
            ins.reg_write = ~m[0];
            ins.writef = 1'($urandom);
            run_instr(ins);
        end

        run_float(OP_FADD, 32'h3FC0_0000, 32'h4010_0000);   // 1.5 + 2.25
        run_float(OP_FSUB, 32'h4040_0000, 32'h3F00_0000);   // 3.0 - 0.5
        run_float(OP_FMUL, 32'h3FC0_0000, 32'h4020_0000);   // 1.5 * 2.5

        // Back to back, FPU and ALU mixed
        run_float(OP_FMUL, 32'h4000_0000, 32'hC040_0000);
        run_instr(random_instr(OP_XOR));
        run_float(OP_FADD, 32'hBF80_0000, 32'h4080_0000);
        run_float(OP_FSUB, 32'h4120_0000, 32'h3FC0_0000);
        run_instr(random_instr(OP_SLT));
        run_float(OP_FMUL, 32'h3F00_0000, 32'h4100_0000);

        @(posedge clk);
        $display("Checks done with %0d errors and %0d assertion failures", errors,
                 i_exec_unit_top.i_stage_sequencer.i_exec_sva.fail_count);
        if (errors == 0 && i_exec_unit_top.i_stage_sequencer.i_exec_sva.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
exec_pkg.sv
alu.sv
fpu.sv
exec_stage.sv
stage_sequencer.sv
exec_unit_top.sv
exec_sva.sv
exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the execute-stage testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f src.f --top-module exec_tb -o exec_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/exec_sim +verilator+error+limit+100 > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
